/* ab_pattern_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module ab_pattern_gen
    import ab_test_pkg::*;
#(
    parameter int AWIDTH = ab_test_pkg::AWIDTH,  // address width
    parameter int DWIDTH = ab_test_pkg::DWIDTH   // data width
)
(
    input  logic                clk,
    input  logic                arst_n,
    input  span_t               span,          // lines under test
    input  logic                step,          // accepted access
    input  logic                first,         // park index at base
    input  logic                pass_inv,      // invert tags
    output logic                last,          // index reached span
    mm_if.master_dat            bus,           // addr / wdat
    output logic                push_tag,      // read accepted, store tag
    output logic [DWIDTH-1:0]   tag            // expected read data
);

    span_t              idx;                   // 0 base, k -> line k-1
    logic [DWIDTH-1:0]  tag_w;

    // --------------------
    // access index
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idx <= '0;
        end else if (first) begin
            idx <= '0;
        end else if (step) begin
            idx <= last ? '0 : idx + 1'b1;     // wrap for the next phase
        end
    end

    assign last = (idx == span);

    // --------------------
    // address and tag
    always_comb begin
        if (idx == '0) begin
            bus.addr = '0;                     // base address
        end else begin
            bus.addr = AWIDTH'(1) << (idx - 1'b1);  // single hot line
        end
    end

    assign tag_w    = DWIDTH'(idx) ^ {DWIDTH{pass_inv}};
    assign bus.wdat = tag_w;
    assign tag      = tag_w;                   // same word goes to checker
    assign push_tag = bus.rreq && !bus.busy;   // read taken by slave

endmodule : ab_pattern_gen

`default_nettype wire

/* ab_read_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module ab_read_checker
    import ab_test_pkg::*;
#(
    parameter int DWIDTH     = ab_test_pkg::DWIDTH,  // data width
    parameter int FIFO_DEPTH = 8                     // > reads in flight
)
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                clear,         // sync flush and zero
    mm_if.monitor               bus,           // rdat / rval tap
    input  logic                push_tag,      // read accepted
    input  logic [DWIDTH-1:0]   tag,           // expected data of that read
    output logic                empty,         // nothing outstanding
    output logic                fault,         // mismatch pulse
    output cnt_t                fault_count    // accumulated faults
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    logic [DWIDTH-1:0]  fifo_mem [FIFO_DEPTH]; // expected tags in issue order
    logic [PW-1:0]      wr_ptr;
    logic [PW-1:0]      rd_ptr;
    logic [CW-1:0]      count;
    logic               full;
    logic               pop;
    logic               mismatch;

    assign empty    = (count == '0);
    assign full     = (count == CW'(FIFO_DEPTH));
    assign pop      = bus.rval && !empty;
    assign mismatch = pop && (bus.rdat != fifo_mem[rd_ptr]);

    // --------------------
    // expected-value FIFO
    always_ff @(posedge clk) begin
        if (push_tag) begin
            fifo_mem[wr_ptr] <= tag;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_tag) begin
                wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_tag, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // idle or push and pop together
            endcase
        end
    end

    // --------------------
    // fault pulse and counter
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fault       <= 1'b0;
            fault_count <= '0;
        end else if (clear) begin
            fault       <= 1'b0;
            fault_count <= '0;
        end else begin
            fault <= mismatch;                 // one cycle after the rval
            if (mismatch && (fault_count != '1)) begin
                fault_count <= fault_count + 1'b1;  // stops at all ones
            end
        end
    end

    // the slave must not return data that was never asked for
    a_no_orphan_rval : assert property (@(posedge clk) disable iff (!arst_n)
        bus.rval |-> !empty);

    a_no_overflow : assert property (@(posedge clk) disable iff (!arst_n)
        push_tag |-> !full);

endmodule : ab_read_checker

`default_nettype wire

/* ab_test_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ab_test_ctrl
    import ab_test_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        clear,                 // sync return to idle
    input  logic        start,                 // test start strobe
    input  span_t       span,                  // lines under test
    output logic        ready,                 // start is accepted
    output logic        done,                  // end of test pulse
    mm_if.master_req    bus,                   // wreq / rreq
    output logic        step,                  // advance pattern index
    output logic        first,                 // hold index at base
    output logic        pass_inv,              // pass 1, inverted tags
    input  logic        last,                  // final access of phase
    input  logic        empty,                 // no read outstanding
    output logic        chk_clear              // checker clear
);

    ab_state_e  state;
    ab_state_e  state_nxt;
    logic       pass;                          // 0 plain, 1 inverted
    logic       pass_nxt;
    logic       take_start;                    // start seen while ready
    logic       acc;                           // request taken this cycle

    assign take_start = ready && start;
    assign acc        = (bus.wreq || bus.rreq) && !bus.busy;

    // --------------------
    // next state
    always_comb begin
        state_nxt = state;
        pass_nxt  = pass;
        case (state)
            IDLE, DONE: begin
                if (take_start) begin
                    state_nxt = WRITE;
                    pass_nxt  = 1'b0;          // always open with plain tags
                end else begin
                    state_nxt = IDLE;
                end
            end
            WRITE: begin
                if (acc && last) begin
                    state_nxt = READ;          // all tags written
                end
            end
            READ: begin
                if (acc && last) begin
                    if (pass) begin
                        state_nxt = DRAIN;     // both passes issued
                    end else begin
                        state_nxt = WRITE;     // second pass, inverted
                        pass_nxt  = 1'b1;
                    end
                end
            end
            DRAIN: begin
                if (empty) begin
                    state_nxt = DONE;          // last rval compared
                end
            end
            default: state_nxt = IDLE;
        endcase
        if (clear) begin
            state_nxt = IDLE;                  // clear overrides everything
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            pass  <= 1'b0;
        end else begin
            state <= state_nxt;
            pass  <= pass_nxt;
        end
    end

    // --------------------
    // outputs
    assign ready     = (state == IDLE) || (state == DONE);
    assign done      = (state == DONE);
    assign bus.wreq  = (state == WRITE);
    assign bus.rreq  = (state == READ);
    assign step      = acc;                    // only on accepted cycles
    assign first     = ready;                  // index parked at base between tests
    assign pass_inv  = pass;
    assign chk_clear = clear;

    a_span_ok : assert property (@(posedge clk) disable iff (!arst_n)
        take_start && !clear |-> (span >= span_t'(1)) && (span <= span_t'(AWIDTH)));

endmodule : ab_test_ctrl

`default_nettype wire

/* ab_test_pkg.sv */
`default_nettype none

package ab_test_pkg;

    // --------------------
    // bus geometry
    parameter int AWIDTH = 8;                  // address lines on the tester side
    parameter int DWIDTH = 8;                  // data width

    typedef logic [AWIDTH-1:0] addr_t;         // address word
    typedef logic [DWIDTH-1:0] data_t;         // data word

    // --------------------
    // test control
    typedef logic [3:0] span_t;                // lines under test, 1..AWIDTH
    typedef logic [7:0] cnt_t;                 // fault counter, saturates

    typedef enum logic [2:0] {
        IDLE,                                  // waiting for start
        WRITE,                                 // tag writes of one pass
        READ,                                  // read-back of one pass
        DRAIN,                                 // outstanding reads return
        DONE                                   // done pulse
    } ab_state_e;

endpackage : ab_test_pkg

`default_nettype wire

/* mm_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mm_if
    import ab_test_pkg::*;
();

    addr_t  addr;                              // access address
    logic   wreq;                              // write request
    data_t  wdat;                              // write data
    logic   rreq;                              // read request
    data_t  rdat;                              // read data, RDDELAY after accept
    logic   rval;                              // read data valid
    logic   busy;                              // slave stall, request held

    // request side, owned by the FSM
    modport master_req (output wreq, rreq, input busy);

    // address and data side, owned by the pattern datapath
    modport master_dat (output addr, wdat, input rreq, busy);

    modport slave (input addr, wreq, wdat, rreq, output rdat, rval, busy);

    // passive tap for the read checker
    modport monitor (input rreq, busy, rdat, rval);

endinterface : mm_if

`default_nettype wire

/* mm_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module mm_ram
    import ab_test_pkg::*;
#(
    parameter int RAM_AW         = 6,          // decoded address bits
    parameter int RDDELAY        = 4,          // read latency, >= 1
    parameter int REFRESH_PERIOD = 32          // cycles between refreshes
)
(
    input  logic    clk,
    input  logic    arst_n,
    mm_if.slave     bus
);

    localparam int RW = $clog2(REFRESH_PERIOD);

    data_t          mem [2**RAM_AW];           // upper address bits ignored
    logic [RW-1:0]  ref_cnt;                   // refresh timer
    logic           wr_acc;
    logic           rd_acc;
    logic [RDDELAY-1:0] val_pipe;              // read valid shift
    data_t          dat_pipe [RDDELAY];        // read data shift

    assign wr_acc = bus.wreq && !bus.busy;
    assign rd_acc = bus.rreq && !bus.busy;

    // --------------------
    // refresh timer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ref_cnt <= '0;
        end else begin
            ref_cnt <= (ref_cnt == RW'(REFRESH_PERIOD - 1)) ? '0 : ref_cnt + 1'b1;
        end
    end

    // last two counts of each period stall the bus
    assign bus.busy = (ref_cnt >= RW'(REFRESH_PERIOD - 2));

    // --------------------
    // storage and read data pipe
    always_ff @(posedge clk) begin
        if (wr_acc) begin
            mem[bus.addr[RAM_AW-1:0]] <= bus.wdat;  // aliases above RAM_AW
        end
        dat_pipe[0] <= mem[bus.addr[RAM_AW-1:0]];
        for (int i = 1; i < RDDELAY; i++) begin
            dat_pipe[i] <= dat_pipe[i-1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            val_pipe <= '0;
        end else begin
            val_pipe[0] <= rd_acc;
            for (int i = 1; i < RDDELAY; i++) begin
                val_pipe[i] <= val_pipe[i-1];
            end
        end
    end

    assign bus.rval = val_pipe[RDDELAY-1];
    assign bus.rdat = dat_pipe[RDDELAY-1];

    // a stalled request has to come back unchanged in the next cycle
    a_hold_under_busy : assert property (@(posedge clk) disable iff (!arst_n)
        (bus.wreq || bus.rreq) && bus.busy |=>
            $stable(bus.wreq) && $stable(bus.rreq)
            && $stable(bus.addr) && $stable(bus.wdat));

endmodule : mm_ram

`default_nettype wire

/* ram_ab_test_top.f */
ab_test_pkg.sv
mm_if.sv
ab_test_ctrl.sv
ab_pattern_gen.sv
ab_read_checker.sv
mm_ram.sv
ram_ab_test_top.sv
ram_ab_test_top_tb.sv

/* ram_ab_test_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_ab_test_top
    import ab_test_pkg::*;
#(
    parameter int RAM_AW         = 6,          // decoded RAM address bits
    parameter int RDDELAY        = 4,          // RAM read latency
    parameter int REFRESH_PERIOD = 32,         // RAM refresh interval
    parameter int FIFO_DEPTH     = 8           // must exceed RDDELAY
)
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    clear,
    input  logic    start,
    input  span_t   span,
    output logic    ready,
    output logic    fault,
    output logic    done,
    output cnt_t    fault_count
);

    logic           step;
    logic           first;
    logic           pass_inv;
    logic           last;
    logic           empty;
    logic           chk_clear;
    logic           push_tag;
    data_t          tag;

    mm_if bus ();                              // tester to RAM bus

    // --------------------
    // tester
    ab_test_ctrl the_ab_test_ctrl (
        .clk         (clk),                    // i
        .arst_n      (arst_n),                 // i
        .clear       (clear),                  // i
        .start       (start),                  // i
        .span        (span),                   // i
        .ready       (ready),                  // o
        .done        (done),                   // o
        .bus         (bus.master_req),         // wreq / rreq
        .step        (step),                   // o
        .first       (first),                  // o
        .pass_inv    (pass_inv),               // o
        .last        (last),                   // i
        .empty       (empty),                  // i
        .chk_clear   (chk_clear)               // o
    );

    ab_pattern_gen #(
        .AWIDTH      (AWIDTH),
        .DWIDTH      (DWIDTH)
    ) the_ab_pattern_gen (
        .clk         (clk),                    // i
        .arst_n      (arst_n),                 // i
        .span        (span),                   // i
        .step        (step),                   // i
        .first       (first),                  // i
        .pass_inv    (pass_inv),               // i
        .last        (last),                   // o
        .bus         (bus.master_dat),         // addr / wdat
        .push_tag    (push_tag),               // o
        .tag         (tag)                     // o
    );

    ab_read_checker #(
        .DWIDTH      (DWIDTH),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) the_ab_read_checker (
        .clk         (clk),                    // i
        .arst_n      (arst_n),                 // i
        .clear       (chk_clear),              // i
        .bus         (bus.monitor),            // rdat / rval tap
        .push_tag    (push_tag),               // i
        .tag         (tag),                    // i
        .empty       (empty),                  // o
        .fault       (fault),                  // o
        .fault_count (fault_count)             // o
    );

    // --------------------
    // memory under test
    mm_ram #(
        .RAM_AW         (RAM_AW),
        .RDDELAY        (RDDELAY),
        .REFRESH_PERIOD (REFRESH_PERIOD)
    ) the_mm_ram (
        .clk         (clk),                    // i
        .arst_n      (arst_n),                 // i
        .bus         (bus.slave)
    );

endmodule : ram_ab_test_top

`default_nettype wire

/* ram_ab_test_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_ab_test_top_tb
    import ab_test_pkg::*;
;

    localparam int RAM_AW         = 6;         // RAM decodes fewer lines than the tester drives
    localparam int RDDELAY        = 4;
    localparam int REFRESH_PERIOD = 32;
    localparam int FIFO_DEPTH     = 8;

    logic   clk;
    logic   arst_n;
    logic   clear;
    logic   start;
    span_t  span;
    logic   ready;
    logic   fault;
    logic   done;
    cnt_t   fault_count;

    // one entry per line of the test file
    logic   clr_q [$];
    span_t  span_q [$];
    cnt_t   faults_q [$];                      // fault pulses of that test
    cnt_t   total_q [$];                       // fault_count after that test

    int     errors;
    int     checks;
    int     cycles;                            // clock edges since reset release
    int     cycle_limit;
    logic   timed_out;

    ram_ab_test_top #(
        .RAM_AW         (RAM_AW),
        .RDDELAY        (RDDELAY),
        .REFRESH_PERIOD (REFRESH_PERIOD),
        .FIFO_DEPTH     (FIFO_DEPTH)
    ) ram_ab_test_top_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .clear       (clear),
        .start       (start),
        .span        (span),
        .ready       (ready),
        .fault       (fault),
        .done        (done),
        .fault_count (fault_count)
    );

    // --------------------
    // clock, 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // next drive and sample point, 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
        cycles++;
    endtask

    // --------------------
    // compare tasks
    task automatic check_cnt(input string name, input cnt_t exp, input cnt_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // --------------------
    // test file, '#' lines are comments
    task automatic load_tests();
        int   fd;
        int   n;
        int   ch;
        int   c_clr;
        int   c_span;
        int   c_faults;
        int   c_total;
        logic eof;
        fd = $fopen("ram_ab_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open ram_ab_tests.txt");
        end else begin
            eof = 1'b0;
            while (!eof) begin
                n = $fscanf(fd, "%d %d %d %d", c_clr, c_span, c_faults, c_total);
                if (n == 4) begin
                    clr_q.push_back(c_clr != 0);
                    span_q.push_back(span_t'(c_span));
                    faults_q.push_back(cnt_t'(c_faults));
                    total_q.push_back(cnt_t'(c_total));
                end else if (n < 0) begin
                    eof = 1'b1;            // end of file
                end else if (n == 0) begin
                    ch = $fgetc(fd);       // skip the rest of a comment line
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                    if (ch == -1) begin
                        eof = 1'b1;
                    end
                end else begin
                    errors++;
                    $display("ram_ab_tests.txt has a line with fewer than four numbers");
                    eof = 1'b1;
                end
            end
            $fclose(fd);
        end
    endtask

    // --------------------
    // one test: optional clear, start with a repeated strobe, wait for done
    task automatic run_test(input int idx);
        cnt_t pulses;
        pulses = '0;
        if (clr_q[idx]) begin
            clear = 1'b1;
            tick();
            clear = 1'b0;
            check_cnt("fault_count", cnt_t'(0), fault_count);  // zeroed by clear
        end
        check_bit("ready", 1'b1, ready);
        start = 1'b1;
        span  = span_q[idx];
        tick();                                // start taken here
        check_bit("ready", 1'b0, ready);
        tick();                                // same strobe again, ready low so ignored
        start = 1'b0;
        while (!done && !timed_out) begin
            if (fault) begin
                pulses++;
            end
            check_bit("ready", 1'b0, ready);   // busy until done
            if (cycles >= cycle_limit) begin
                timed_out = 1'b1;
                errors++;
                $display("timeout: done never arrived");
            end else begin
                tick();
            end
        end
        if (!timed_out) begin
            if (fault) begin
                pulses++;
            end
            check_bit("ready", 1'b1, ready);   // back up with done
            check_cnt("fault pulses", faults_q[idx], pulses);
            check_cnt("fault_count", total_q[idx], fault_count);
            tick();
            check_bit("done", 1'b0, done);     // single pulse, no restart
            check_bit("ready", 1'b1, ready);   // idle again
            check_bit("fault", 1'b0, fault);
        end
    endtask

    // --------------------
    // main sequence
    initial begin
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        cycle_limit = 0;
        timed_out   = 1'b0;
        arst_n      = 1'b0;
        clear       = 1'b0;
        start       = 1'b0;
        span        = span_t'(1);
        load_tests();
        cycle_limit = span_q.size() * (4 * (AWIDTH + 1) + RDDELAY + 20) * 2;
        repeat (2) @(posedge clk);             // reset over two cycles
        #1;
        arst_n = 1'b1;
        check_bit("ready", 1'b1, ready);
        check_cnt("fault_count", cnt_t'(0), fault_count);
        repeat (3) begin                       // quiet until the first start
            check_bit("done", 1'b0, done);
            check_bit("fault", 1'b0, fault);
            tick();
        end
        if (span_q.size() == 0) begin
            errors++;
            $display("no tests were read from ram_ab_tests.txt");
        end
        for (int i = 0; i < span_q.size() && !timed_out; i++) begin
            run_test(i);
        end
        $display("tests %0d, checks %0d, errors %0d", span_q.size(), checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : ram_ab_test_top_tb

`default_nettype wire

/* ram_ab_tests.txt */
# columns: clear span fault_pulses fault_count_after
# clear 1 zeroes the count before the test starts
0 1 0 0
0 2 0 0
0 3 0 0
0 4 0 0
0 5 0 0
0 6 0 0
0 7 2 2
0 8 4 6
0 7 2 8
1 8 4 4
0 6 0 4
1 7 2 2
0 8 4 6
0 1 0 6
1 6 0 0
0 8 4 4

/* run_sim.sh */
#!/bin/sh
# build and run the address-bus tester simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module ram_ab_test_top_tb -f ram_ab_test_top.f -o sim_ram_ab
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_ram_ab)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
